/* Makefile */
VERILATOR ?= verilator
TOP ?= tbTop8227
FILELIST ?= filelist.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --assert
PASS_MSG ?= Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* filelist.f */
hdl/cpuPkg.sv
hdl/pulseSlower.sv
hdl/instructionLoader.sv
hdl/opcodeDecoder.sv
hdl/cycleSequencer.sv
hdl/internalDataflow.sv
hdl/top8227.sv
verification/clockGen.sv
verification/top8227_assertions.sv
verification/tbTop8227.sv

/* hdl/cpuPkg.sv */
package cpuPkg;

    typedef logic [7:0] byteT;
    typedef logic [15:0] addrT;

    typedef enum logic [5:0] {
        INS_LDA,
        INS_ADC,
        INS_AND,
        INS_ORA,
        INS_EOR,
        INS_STA,
        INS_JMP,
        INS_CLC,
        INS_SEC,
        INS_NOP,
        INS_BAD
    } instrT;

    typedef enum logic [3:0] {
        AM_IMPLIED,
        AM_IMMEDIATE,
        AM_ZEROPAGE,
        AM_ABSOLUTE
    } addrModeT;

    typedef enum logic [2:0] {
        CYC_RESET0,
        CYC_RESET1,
        CYC_FETCH,
        CYC_T1,
        CYC_T2,
        CYC_T3
    } cycleT;

    localparam int NUMFLAGS = 12;
    typedef logic [NUMFLAGS-1:0] ctrlFlagsT;

    // control flag positions
    localparam int ADDR_FROM_PC = 0;
    localparam int ADDR_FROM_OPERAND = 1;
    localparam int ADDR_FROM_VECTOR = 2;
    localparam int INCREMENT_PC = 3;
    localparam int LOAD_OPERAND_LOW = 4;
    localparam int LOAD_PC_FROM_OPERAND = 5;
    localparam int ALU_TO_ACC = 6;
    localparam int SET_WRITE_FLAG = 7;
    localparam int LOAD_CARRY_FLAG = 8;
    localparam int CARRY_VALUE = 9;
    localparam int LOAD_NZ_FLAGS = 10;
    localparam int END_INSTRUCTION = 11;

    localparam addrT RESET_VECTOR = 16'hFFFC;

    // processor status bits
    localparam int PSR_C = 0;
    localparam int PSR_Z = 1;
    localparam int PSR_N = 7;

endpackage

/* hdl/cycleSequencer.sv */
module cycleSequencer import cpuPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  logic      enableFFs,
    input  instrT     instructionCode,
    input  addrModeT  addressingCode,
    input  logic      resetRunning,
    output ctrlFlagsT outFlags,
    output logic      loadNextInstruction
);

    cycleT state;
    cycleT nextState;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= CYC_RESET0;
        end else if (enableFFs) begin
            state <= nextState;
        end
    end

    always_comb begin
        outFlags = '0;
        loadNextInstruction = 1'b0;
        nextState = CYC_FETCH;
        case (state)
            // vector low byte at FFFC, then point at FFFD
            CYC_RESET0: begin
                if (resetRunning) begin
                    outFlags[LOAD_OPERAND_LOW] = 1'b1;
                    outFlags[ADDR_FROM_VECTOR] = 1'b1;
                    nextState = CYC_RESET1;
                end
            end
            CYC_RESET1: begin
                outFlags[LOAD_PC_FROM_OPERAND] = 1'b1;
                outFlags[ADDR_FROM_PC] = 1'b1;
            end
            CYC_FETCH: begin
                outFlags[END_INSTRUCTION] = 1'b1;
                outFlags[INCREMENT_PC] = 1'b1;
                outFlags[ADDR_FROM_PC] = 1'b1;
                loadNextInstruction = 1'b1;
                nextState = CYC_T1;
            end
            CYC_T1: begin
                outFlags[ADDR_FROM_PC] = 1'b1;
                case (addressingCode)
                    AM_IMMEDIATE: begin
                        outFlags[INCREMENT_PC] = 1'b1;
                        outFlags[ALU_TO_ACC] = 1'b1;
                        outFlags[LOAD_NZ_FLAGS] = 1'b1;
                        outFlags[LOAD_CARRY_FLAG] = (instructionCode == INS_ADC);
                    end
                    // next cycle writes to the zero page byte just read
                    AM_ZEROPAGE: begin
                        outFlags[INCREMENT_PC] = 1'b1;
                        outFlags[ADDR_FROM_PC] = 1'b0;
                        outFlags[ADDR_FROM_OPERAND] = 1'b1;
                        outFlags[SET_WRITE_FLAG] = 1'b1;
                        nextState = CYC_T2;
                    end
                    AM_ABSOLUTE: begin
                        outFlags[INCREMENT_PC] = 1'b1;
                        outFlags[LOAD_OPERAND_LOW] = 1'b1;
                        nextState = CYC_T2;
                    end
                    default: begin
                        outFlags[LOAD_CARRY_FLAG] = (instructionCode == INS_CLC) ||
                                                    (instructionCode == INS_SEC);
                        outFlags[CARRY_VALUE] = (instructionCode == INS_SEC);
                    end
                endcase
            end
            CYC_T2: begin
                outFlags[ADDR_FROM_PC] = 1'b1;
                outFlags[LOAD_PC_FROM_OPERAND] = (addressingCode == AM_ABSOLUTE);
            end
            default: begin
                outFlags[ADDR_FROM_PC] = 1'b1;
            end
        endcase
    end

endmodule

/* hdl/instructionLoader.sv */
module instructionLoader import cpuPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic enableFFs,
    input  logic loadNextInstruction,
    input  byteT externalDB,
    output byteT nextInstruction,
    output logic resetRunning
);

    localparam byteT NOP_OPCODE = 8'hEA;

    byteT opcodeReg;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            opcodeReg <= '0;
        end else if (enableFFs && loadNextInstruction) begin
            opcodeReg <= externalDB;
        end
    end

    // reset sequence runs until the first real opcode is fetched
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resetRunning <= 1'b1;
        end else if (enableFFs && loadNextInstruction) begin
            resetRunning <= 1'b0;
        end
    end

    // inject a harmless opcode while the vector is being read
    always_comb begin
        if (resetRunning) begin
            nextInstruction = NOP_OPCODE;
        end else begin
            nextInstruction = opcodeReg;
        end
    end

endmodule

/* hdl/internalDataflow.sv */
module internalDataflow import cpuPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  ctrlFlagsT flags,
    input  byteT      externalDBRead,
    output byteT      externalDBWrite,
    output byteT      externalAddressBusLowOutput,
    output byteT      externalAddressBusHighOutput,
    output logic      readNotWrite
);

    // 6502 group one operation field, opcode bits 7 to 5
    localparam logic [2:0] OP_ORA = 3'b000;
    localparam logic [2:0] OP_AND = 3'b001;
    localparam logic [2:0] OP_EOR = 3'b010;
    localparam logic [2:0] OP_ADC = 3'b011;
    localparam logic [2:0] OP_LDA = 3'b101;

    addrT pc;
    addrT pcNext;
    addrT addressReg;
    addrT addressNext;
    byteT operandLow;
    byteT accumulator;
    byteT psr;
    byteT aluResult;
    logic [2:0] aluOp;
    logic [8:0] sum;
    logic addressLoad;

    always_comb begin
        if (flags[LOAD_PC_FROM_OPERAND]) begin
            pcNext = {externalDBRead, operandLow};
        end else if (flags[INCREMENT_PC]) begin
            pcNext = pc + 16'd1;
        end else begin
            pcNext = pc;
        end
    end

    assign sum = {1'b0, accumulator} + {1'b0, externalDBRead} + {8'd0, psr[PSR_C]};

    always_comb begin
        case (aluOp)
            OP_ORA:  aluResult = accumulator | externalDBRead;
            OP_AND:  aluResult = accumulator & externalDBRead;
            OP_EOR:  aluResult = accumulator ^ externalDBRead;
            OP_ADC:  aluResult = sum[7:0];
            OP_LDA:  aluResult = externalDBRead;
            default: aluResult = externalDBRead;
        endcase
    end

    // address for the following cycle
    always_comb begin
        if (flags[ADDR_FROM_VECTOR]) begin
            addressNext = RESET_VECTOR + 16'd1;
        end else if (flags[ADDR_FROM_OPERAND]) begin
            addressNext = {8'h00, externalDBRead};
        end else begin
            addressNext = pcNext;
        end
    end

    assign addressLoad = flags[ADDR_FROM_PC] | flags[ADDR_FROM_OPERAND] |
                         flags[ADDR_FROM_VECTOR];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            operandLow <= '0;
            accumulator <= '0;
            psr <= '0;
            aluOp <= '0;
        end else begin
            pc <= pcNext;
            if (flags[LOAD_OPERAND_LOW]) begin
                operandLow <= externalDBRead;
            end
            if (flags[ALU_TO_ACC]) begin
                accumulator <= aluResult;
            end
            if (flags[LOAD_NZ_FLAGS]) begin
                psr[PSR_N] <= aluResult[7];
                psr[PSR_Z] <= (aluResult == 8'd0);
            end
            if (flags[LOAD_CARRY_FLAG]) begin
                psr[PSR_C] <= flags[ALU_TO_ACC] ? sum[8] : flags[CARRY_VALUE];
            end
            // opcode byte is on the bus at the end of the fetch
            if (flags[END_INSTRUCTION]) begin
                aluOp <= externalDBRead[7:5];
            end
        end
    end

    // first cycle after reset reads the vector low byte
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            addressReg <= RESET_VECTOR;
            readNotWrite <= 1'b1;
        end else if (addressLoad) begin
            addressReg <= addressNext;
            readNotWrite <= ~flags[SET_WRITE_FLAG];
        end
    end

    assign externalDBWrite = accumulator;
    assign externalAddressBusLowOutput = addressReg[7:0];
    assign externalAddressBusHighOutput = addressReg[15:8];

endmodule

/* hdl/opcodeDecoder.sv */
module opcodeDecoder import cpuPkg::*; (
    input  byteT     opcode,
    output instrT    instructionCode,
    output addrModeT addressingCode
);

    always_comb begin
        case (opcode)
            8'hA9: begin
                instructionCode = INS_LDA;
                addressingCode = AM_IMMEDIATE;
            end
            8'h69: begin
                instructionCode = INS_ADC;
                addressingCode = AM_IMMEDIATE;
            end
            8'h29: begin
                instructionCode = INS_AND;
                addressingCode = AM_IMMEDIATE;
            end
            8'h09: begin
                instructionCode = INS_ORA;
                addressingCode = AM_IMMEDIATE;
            end
            8'h49: begin
                instructionCode = INS_EOR;
                addressingCode = AM_IMMEDIATE;
            end
            8'h85: begin
                instructionCode = INS_STA;
                addressingCode = AM_ZEROPAGE;
            end
            8'h4C: begin
                instructionCode = INS_JMP;
                addressingCode = AM_ABSOLUTE;
            end
            8'h18: begin
                instructionCode = INS_CLC;
                addressingCode = AM_IMPLIED;
            end
            8'h38: begin
                instructionCode = INS_SEC;
                addressingCode = AM_IMPLIED;
            end
            8'hEA: begin
                instructionCode = INS_NOP;
                addressingCode = AM_IMPLIED;
            end
            // unsupported opcodes run as a two cycle nop
            default: begin
                instructionCode = INS_BAD;
                addressingCode = AM_IMPLIED;
            end
        endcase
    end

endmodule

/* hdl/pulseSlower.sv */
module pulseSlower #(
    parameter int DIVIDE = 2
) (
    input  logic clk,
    input  logic arstN,
    output logic slowPulse
);

    localparam int CW = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;
    localparam logic [CW-1:0] LAST = CW'(DIVIDE - 1);

    logic [CW-1:0] count;

    // one clock high per DIVIDE clocks, always high when DIVIDE is 1
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
            slowPulse <= 1'b0;
        end else begin
            if (count == LAST) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            slowPulse <= (count == LAST);
        end
    end

endmodule

/* hdl/top8227.sv */
module top8227 import cpuPkg::*; #(
    parameter int DIVIDE = 2
) (
    input  logic clk,
    input  logic arstN,
    input  logic ready,
    input  byteT dataBusInput,
    output byteT dataBusOutput,
    output byteT addressBusHigh,
    output byteT addressBusLow,
    output logic sync,
    output logic readNotWrite
);

    logic      slowPulse;
    logic      enableFFs;
    logic      resetRunning;
    logic      loadNextInstruction;
    byteT      opcode;
    instrT     instructionCode;
    addrModeT  addressingCode;
    ctrlFlagsT preFlags;
    ctrlFlagsT flags;

    // ready only stalls read cycles
    assign enableFFs = slowPulse & (ready | ~readNotWrite);

    assign sync = preFlags[END_INSTRUCTION];

    // nothing moves unless this clock is enabled
    assign flags = enableFFs ? preFlags : '0;

    pulseSlower #(.DIVIDE(DIVIDE)) pulseSlower (
        .clk(clk),
        .arstN(arstN),
        .slowPulse(slowPulse)
    );

    instructionLoader instructionLoader (
        .clk(clk),
        .arstN(arstN),
        .enableFFs(enableFFs),
        .loadNextInstruction(loadNextInstruction),
        .externalDB(dataBusInput),
        .nextInstruction(opcode),
        .resetRunning(resetRunning)
    );

    opcodeDecoder opcodeDecoder (
        .opcode(opcode),
        .instructionCode(instructionCode),
        .addressingCode(addressingCode)
    );

    cycleSequencer cycleSequencer (
        .clk(clk),
        .arstN(arstN),
        .enableFFs(enableFFs),
        .instructionCode(instructionCode),
        .addressingCode(addressingCode),
        .resetRunning(resetRunning),
        .outFlags(preFlags),
        .loadNextInstruction(loadNextInstruction)
    );

    internalDataflow internalDataflow (
        .clk(clk),
        .arstN(arstN),
        .flags(flags),
        .externalDBRead(dataBusInput),
        .externalDBWrite(dataBusOutput),
        .externalAddressBusLowOutput(addressBusLow),
        .externalAddressBusHighOutput(addressBusHigh),
        .readNotWrite(readNotWrite)
    );

endmodule

/* verification/clockGen.sv */
module clockGen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

/* verification/tbTop8227.sv */
module tbTop8227 import cpuPkg::*; ();

    localparam int NROWS = 8;
    localparam int WRITE_TIMEOUT = 4000;
    localparam int LOOP_TIMEOUT = 400;
    localparam int LOOP_FETCHES = 4;
    localparam addrT PROGRAM_START = 16'h0200;

    typedef struct packed {
        byteT op;
        byteT load;
        byteT operand;
        byteT setup;
        byteT target;
    } rowT;

    logic clk;
    logic arstN;
    logic ready;
    byteT dataBusInput;
    byteT dataBusOutput;
    byteT addressBusHigh;
    byteT addressBusLow;
    logic sync;
    logic readNotWrite;

    byteT mem [0:65535];
    rowT progRows [$];
    addrT buildAddr;
    addrT jmpAddr;

    // bus observations, cleared at each reset
    logic tracking;
    logic lastRnw;
    logic lastSync;
    addrT lastAddr;
    addrT addrTrace [$];
    logic firstSyncSeen;
    addrT firstSyncAddr;
    addrT lastSyncAddr;
    int syncCount;
    addrT writeAddr [$];
    byteT writeData [$];

    logic randomReady;
    logic [31:0] rngState;
    int errorCount;
    int timeoutCount;

    clockGen #(.PERIOD(40)) clkSource (.clk(clk));

    top8227 #(.DIVIDE(2)) UUT (
        .clk(clk),
        .arstN(arstN),
        .ready(ready),
        .dataBusInput(dataBusInput),
        .dataBusOutput(dataBusOutput),
        .addressBusHigh(addressBusHigh),
        .addressBusLow(addressBusLow),
        .sync(sync),
        .readNotWrite(readNotWrite)
    );

    bind top8227 top8227_assertions busChecks (
        .clk(clk),
        .arstN(arstN),
        .ready(ready),
        .sync(sync),
        .readNotWrite(readNotWrite),
        .addressBusHigh(addressBusHigh),
        .addressBusLow(addressBusLow)
    );

    // combinational memory
    assign dataBusInput = mem[{addressBusHigh, addressBusLow}];

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 6502 result of one row, carry only matters for ADC
    function automatic byteT expectedResult(input rowT row);
        byteT carryIn;
        byteT result;
        carryIn = (row.setup == 8'h38) ? 8'd1 : 8'd0;
        case (row.op)
            8'h69: result = row.load + row.operand + carryIn;
            8'h29: result = row.load & row.operand;
            8'h09: result = row.load | row.operand;
            8'h49: result = row.load ^ row.operand;
            default: result = row.operand;
        endcase
        return result;
    endfunction

    task automatic addRow(input byteT op, input byteT load, input byteT operand,
                          input byteT setup, input byteT target);
        rowT row;
        row.op = op;
        row.load = load;
        row.operand = operand;
        row.setup = setup;
        row.target = target;
        progRows.push_back(row);
    endtask

    task automatic emitByte(input byteT value);
        mem[buildAddr] = value;
        buildAddr = buildAddr + 16'd1;
    endtask

    task automatic buildProgram();
        for (int i = 0; i < 65536; i++) begin
            mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'h5A;
        end
        // op, load, operand, setup, zero page target
        addRow(8'h69, 8'h3C, 8'h51, 8'h18, 8'h10);
        addRow(8'h69, 8'hF0, 8'h20, 8'h38, 8'h11);
        addRow(8'h29, 8'h5A, 8'h0F, 8'h38, 8'h12);
        addRow(8'h09, 8'h80, 8'h01, 8'h18, 8'h13);
        addRow(8'h49, 8'hFF, 8'h0F, 8'h18, 8'h14);
        addRow(8'hA9, 8'h12, 8'h77, 8'h38, 8'h15);
        addRow(8'h69, 8'hFF, 8'h00, 8'h38, 8'h16);
        addRow(8'h49, 8'h55, 8'h55, 8'h38, 8'h17);
        buildAddr = PROGRAM_START;
        for (int i = 0; i < NROWS; i++) begin
            emitByte(progRows[i].setup);
            emitByte(8'hA9);
            emitByte(progRows[i].load);
            emitByte(progRows[i].op);
            emitByte(progRows[i].operand);
            emitByte(8'h85);
            emitByte(progRows[i].target);
        end
        // park in a jump to itself
        jmpAddr = buildAddr;
        emitByte(8'h4C);
        emitByte(jmpAddr[7:0]);
        emitByte(jmpAddr[15:8]);
        mem[16'hFFFC] = PROGRAM_START[7:0];
        mem[16'hFFFD] = PROGRAM_START[15:8];
    endtask

    // one clock: sample the bus on the falling edge, then drive ready
    task automatic stepClock();
        addrT busAddr;
        @(negedge clk);
        busAddr = {addressBusHigh, addressBusLow};
        if (tracking) begin
            if (addrTrace.size() < 2 && (addrTrace.size() == 0 || busAddr != lastAddr)) begin
                addrTrace.push_back(busAddr);
            end
            // one entry per write cycle
            if (!readNotWrite && lastRnw) begin
                writeAddr.push_back(busAddr);
                writeData.push_back(dataBusOutput);
                mem[busAddr] = dataBusOutput;
            end
            if (sync && !lastSync) begin
                syncCount++;
                lastSyncAddr = busAddr;
                if (!firstSyncSeen) begin
                    firstSyncSeen = 1'b1;
                    firstSyncAddr = busAddr;
                end
            end
        end
        lastAddr = busAddr;
        lastRnw = readNotWrite;
        lastSync = sync;
        if (randomReady) begin
            rngState = nextRandom(rngState);
            ready = (rngState[1:0] != 2'b00);
        end else begin
            ready = 1'b1;
        end
    endtask

    task automatic applyReset();
        tracking = 1'b0;
        stepClock();
        arstN = 1'b0;
        stepClock();
        stepClock();
        addrTrace.delete();
        writeAddr.delete();
        writeData.delete();
        firstSyncSeen = 1'b0;
        syncCount = 0;
        lastRnw = 1'b1;
        lastSync = 1'b0;
        arstN = 1'b1;
        tracking = 1'b1;
    endtask

    task automatic checkStartup(input string label);
        assert (addrTrace.size() == 2 && addrTrace[0] == 16'hFFFC && addrTrace[1] == 16'hFFFD)
            else begin
                errorCount++;
                $display("** Error (%0t): %0s reset reads were not FFFC then FFFD", $time, label);
            end
        assert (firstSyncSeen && firstSyncAddr == PROGRAM_START)
            else begin
                errorCount++;
                $display("** Error (%0t): %0s first fetch at %h, expected %h",
                         $time, label, firstSyncAddr, PROGRAM_START);
            end
    endtask

    task automatic checkWrites(input string label);
        for (int i = 0; i < NROWS; i++) begin
            assert (writeAddr[i] == {8'h00, progRows[i].target})
                else begin
                    errorCount++;
                    $display("** Error (%0t): %0s write %0d went to %h, expected %h",
                             $time, label, i, writeAddr[i], {8'h00, progRows[i].target});
                end
            assert (writeData[i] == expectedResult(progRows[i]))
                else begin
                    errorCount++;
                    $display("** Error (%0t): %0s write %0d value %h, expected %h",
                             $time, label, i, writeData[i], expectedResult(progRows[i]));
                end
        end
    endtask

    task automatic runProgram(input string label, input logic useRandom);
        int steps;
        int startSyncs;
        int seenSyncs;
        randomReady = useRandom;
        applyReset();
        steps = 0;
        while (writeAddr.size() < NROWS && steps < WRITE_TIMEOUT) begin
            stepClock();
            steps++;
        end
        if (writeAddr.size() < NROWS) begin
            timeoutCount++;
            $display("CPU stopped fetching in run %0s: %0d of %0d writes after %0d cycles",
                     label, writeAddr.size(), NROWS, steps);
        end else begin
            checkStartup(label);
            checkWrites(label);
            startSyncs = syncCount;
            seenSyncs = syncCount;
            steps = 0;
            while (syncCount - startSyncs < LOOP_FETCHES && steps < LOOP_TIMEOUT) begin
                stepClock();
                steps++;
                if (syncCount != seenSyncs) begin
                    seenSyncs = syncCount;
                    assert (lastSyncAddr == jmpAddr)
                        else begin
                            errorCount++;
                            $display("** Error (%0t): %0s fetch at %h after the last store",
                                     $time, label, lastSyncAddr);
                        end
                end
            end
            if (syncCount - startSyncs < LOOP_FETCHES) begin
                timeoutCount++;
                $display("CPU stopped fetching in run %0s: the final jump loop never ran", label);
            end
            assert (writeAddr.size() == NROWS)
                else begin
                    errorCount++;
                    $display("** Error (%0t): %0s saw %0d writes, expected %0d",
                             $time, label, writeAddr.size(), NROWS);
                end
        end
    endtask

    task automatic finishRun();
        $display("Checks failed: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        arstN = 1'b1;
        ready = 1'b1;
        randomReady = 1'b0;
        rngState = 32'h92b1;
        tracking = 1'b0;
        errorCount = 0;
        timeoutCount = 0;
        buildProgram();
        runProgram("ready high", 1'b0);
        // same program again with ready stalling reads
        if (timeoutCount == 0) begin
            runProgram("ready random", 1'b1);
        end
        finishRun();
    end

endmodule

/* verification/top8227_assertions.sv */
module top8227_assertions import cpuPkg::*; (
    input logic clk,
    input logic arstN,
    input logic ready,
    input logic sync,
    input logic readNotWrite,
    input byteT addressBusHigh,
    input byteT addressBusLow
);

    addrT busAddr;

    assign busAddr = {addressBusHigh, addressBusLow};

    // reset always leaves the bus in a read cycle
    resetReads: assert property (@(posedge clk) !arstN |-> readNotWrite)
        else $error("readNotWrite low while reset is held");

    syncOnRead: assert property (@(posedge clk) disable iff (!arstN)
        sync |-> readNotWrite)
        else $error("sync high during a write cycle");

    // a stalled read keeps its address
    stallHoldsAddress: assert property (@(posedge clk) disable iff (!arstN)
        (readNotWrite && !ready) |=> $stable(busAddr))
        else $error("address moved during a stalled read");

endmodule
